/* all.f */
score_pkg.sv
move_locate.sv
line_counter.sv
score_merge.sv
move_score.sv
tb_clock_gen.sv
tb_move_score.sv

/* line_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module line_counter
    import score_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  plane_t plane,
    input  row_t   move_row,
    input  col_t   move_col,
    output logic   four_found,
    output count_t three_count,
    output col_t   col_out
);

    int row_i;
    int col_i;

    logic                vert4;
    logic [RUN_FOUR-1:0] horiz4;
    logic [RUN_FOUR-1:0] rise4;
    logic [RUN_FOUR-1:0] fall4;

    logic                 vert3;
    logic [RUN_THREE-1:0] horiz3;
    logic [RUN_THREE-1:0] rise3;
    logic [RUN_THREE-1:0] fall3;

    logic   four_c;
    count_t three_c;

    // true when all len cells from (r0, c0) stepping (dr, dc) are set
    // and the whole window lies on the board
    function automatic logic window_full(
        input plane_t p,
        input int     r0,
        input int     c0,
        input int     dr,
        input int     dc,
        input int     len
    );
        logic full;
        int   r;
        int   c;
        full = 1'b1;
        for (int k = 0; k < RUN_FOUR; k++)
        begin
            r = r0 + dr * k;
            c = c0 + dc * k;
            if (k < len)
            begin
                if (r < 0 || r >= BOARD_ROWS || c < 0 || c >= BOARD_COLS)
                begin
                    full = 1'b0;
                end
                else if (!p[r * BOARD_COLS + c])
                begin
                    full = 1'b0;
                end
            end
        end
        return full;
    endfunction

    assign row_i = int'(move_row);
    assign col_i = int'(move_col);

    ////////////////////////////////////////
    // fours

    // vertical only looks down from the new piece
    always_comb
    begin
        vert4 = window_full(plane, row_i - (RUN_FOUR - 1), col_i, 1, 0, RUN_FOUR);
        for (int s = 0; s < RUN_FOUR; s++)
        begin
            horiz4[s] = window_full(plane, row_i, col_i - s, 0, 1, RUN_FOUR);
            rise4[s]  = window_full(plane, row_i - s, col_i - s, 1, 1, RUN_FOUR);
            fall4[s]  = window_full(plane, row_i + s, col_i - s, -1, 1, RUN_FOUR);
        end
    end

    ////////////////////////////////////////
    // threes

    always_comb
    begin
        vert3 = window_full(plane, row_i - (RUN_THREE - 1), col_i, 1, 0, RUN_THREE);
        for (int s = 0; s < RUN_THREE; s++)
        begin
            horiz3[s] = window_full(plane, row_i, col_i - s, 0, 1, RUN_THREE);
            rise3[s]  = window_full(plane, row_i - s, col_i - s, 1, 1, RUN_THREE);
            fall3[s]  = window_full(plane, row_i + s, col_i - s, -1, 1, RUN_THREE);
        end
    end

    assign four_c = vert4 | (|horiz4) | (|rise4) | (|fall4);

    // at most ten windows
    assign three_c = count_t'($countones({vert3, horiz3, rise3, fall3}));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            four_found  <= 1'b0;
            three_count <= '0;
            col_out     <= '0;
        end
        else
        begin
            four_found  <= four_c;
            three_count <= three_c;
            col_out     <= move_col;
        end
    end

endmodule

`default_nettype wire

/* move_locate.sv */
`timescale 1ns/1ps
`default_nettype none

module move_locate
    import score_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  grid_t        grid,
    input  move_t        ai_move,
    input  move_t        opponent_move,
    output plane_t [1:0] planes,
    output row_t   [1:0] move_rows,
    output col_t   [1:0] move_cols
);

    plane_t       ai_plane;
    plane_t       opp_plane;
    move_t  [1:0] moves;
    row_t   [1:0] row_c;
    col_t   [1:0] col_c;

    // odd bit of a cell is the ai piece, even bit the opponent
    always_comb
    begin
        for (int i = 0; i < PLANE_BITS; i++)
        begin
            ai_plane[i]  = grid[CELL_BITS * i + 1];
            opp_plane[i] = grid[CELL_BITS * i];
        end
    end

    assign moves = {opponent_move, ai_move};

    // bit index to row and column
    always_comb
    begin
        for (int p = 0; p < 2; p++)
        begin
            row_c[p] = row_t'(moves[p] / ROW_BITS);
            col_c[p] = col_t'((moves[p] % ROW_BITS) / CELL_BITS);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            planes    <= '0;
            move_rows <= '0;
            move_cols <= '0;
        end
        else
        begin
            planes    <= {opp_plane, ai_plane};
            move_rows <= row_c;
            move_cols <= col_c;
        end
    end

endmodule

`default_nettype wire

/* move_score.sv */
`timescale 1ns/1ps
`default_nettype none

module move_score
    import score_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  grid_t  grid,
    input  move_t  ai_move,
    input  move_t  opponent_move,
    output score_t score
);

    // index 0 is ai, 1 is opponent
    plane_t [1:0] planes;
    row_t   [1:0] move_rows;
    col_t   [1:0] move_cols;
    logic   [1:0] four_found;
    count_t [1:0] three_count;
    col_t   [1:0] col_out;

    move_locate u_move_locate (
        .clk           (clk),
        .rst_n         (rst_n),
        .grid          (grid),
        .ai_move       (ai_move),
        .opponent_move (opponent_move),
        .planes        (planes),
        .move_rows     (move_rows),
        .move_cols     (move_cols)
    );

    ////////////////////////////////////////
    // one counter per player

    for (genvar i = 0; i < 2; i++)
    begin : g_player
        line_counter u_line_counter (
            .clk         (clk),
            .rst_n       (rst_n),
            .plane       (planes[i]),
            .move_row    (move_rows[i]),
            .move_col    (move_cols[i]),
            .four_found  (four_found[i]),
            .three_count (three_count[i]),
            .col_out     (col_out[i])
        );
    end

    // centre bonus uses the ai column
    score_merge u_score_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .four_found  (four_found),
        .three_count (three_count),
        .ai_col      (col_out[0]),
        .score       (score)
    );

endmodule

`default_nettype wire

/* move_score_patterns.txt */
// grid (84 bits) ai_move opponent_move expected_score
// every field in hex, one vector per line
000000000000000000000 00 00 0C9
000000002000800200081 31 00 1FF
4000000000000000002A8 05 52 1FF
400000002000200020002 11 52 1FF
400000000080080080080 1F 52 1FF
000800040010004001000 47 36 000
0000000000000001540AA 07 0E 1FF
4000000000000000002A0 07 52 0D9
0000000000102A4009002 1D 28 0D3
020000000001001001500 4D 0C 0BB
000000008802A10A84081 23 1C 0ED
A80200080000000000001 53 00 0DD
400000000000002222222 01 52 0C9
400000000000002222222 11 52 0CB
400000000000002222222 05 52 0CD
400000000000002222222 15 52 0CF
400000000000002222222 09 52 0CD
400000000000002222222 19 52 0CB
400000000000002222222 0D 52 0C9

/* score_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module score_merge
    import score_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic   [1:0] four_found,
    input  count_t [1:0] three_count,
    input  col_t         ai_col,
    output score_t       score
);

    col_t   edge_dist;
    int     bonus;
    int     weighted;
    score_t score_c;

    // distance to the nearer side edge
    assign edge_dist = (ai_col > col_t'((BOARD_COLS - 1) / 2))
                     ? col_t'(BOARD_COLS - 1) - ai_col
                     : ai_col;

    assign bonus = 2 * int'(edge_dist) + 1;

    assign weighted = SCORE_BASE
                    + THREE_WEIGHT * (int'(three_count[0]) - int'(three_count[1]))
                    + bonus;

    // ai win beats opponent win
    always_comb
    begin
        if (four_found[0])
        begin
            score_c = score_t'(SCORE_WIN);
        end
        else if (four_found[1])
        begin
            score_c = score_t'(SCORE_LOSS);
        end
        else
        begin
            score_c = score_t'(weighted);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            score <= '0;
        end
        else
        begin
            score <= score_c;
        end
    end

endmodule

`default_nettype wire

/* score_pkg.sv */
`default_nettype none

package score_pkg;

    ////////////////////////////////////////
    // board geometry

    localparam int BOARD_ROWS = 6;
    localparam int BOARD_COLS = 7;
    localparam int CELL_BITS  = 2;
    localparam int ROW_BITS   = BOARD_COLS * CELL_BITS;
    localparam int GRID_BITS  = BOARD_ROWS * ROW_BITS;
    localparam int PLANE_BITS = BOARD_ROWS * BOARD_COLS;

    // line lengths
    localparam int RUN_FOUR  = 4;
    localparam int RUN_THREE = 3;

    ////////////////////////////////////////
    // scoring

    localparam int SCORE_BASE   = 200;
    localparam int THREE_WEIGHT = 10;
    localparam int SCORE_WIN    = 511;
    localparam int SCORE_LOSS   = 0;

    // locate, count, merge
    localparam int PIPE_LATENCY = 3;

    typedef logic [GRID_BITS-1:0]  grid_t;
    // bit row*7+col set when that player owns the cell
    typedef logic [PLANE_BITS-1:0] plane_t;
    typedef logic [6:0]            move_t;
    typedef logic [2:0]            row_t;
    typedef logic [2:0]            col_t;
    typedef logic [3:0]            count_t;
    typedef logic [8:0]            score_t;

endpackage

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 100 ns period
    localparam int HALF_PERIOD = 50;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* tb_move_score.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_move_score
    import score_pkg::*;
();

    localparam int MAX_VECTORS  = 64;
    localparam int RESET_CYCLES = 10;
    localparam int SETTLE_LIMIT = 20;
    localparam int DRIVE_DELAY  = 10;
    localparam int LINE_CHARS   = 128;

    logic   clk;
    logic   rst_n;
    grid_t  grid;
    move_t  ai_move;
    move_t  opponent_move;
    score_t score;

    grid_t  vec_grid  [MAX_VECTORS];
    move_t  vec_ai    [MAX_VECTORS];
    move_t  vec_opp   [MAX_VECTORS];
    score_t vec_score [MAX_VECTORS];
    int     num_vectors;
    score_t expected_q [$];

    tb_clock_gen u_clk (
        .clk (clk)
    );

    move_score u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .grid          (grid),
        .ai_move       (ai_move),
        .opponent_move (opponent_move),
        .score         (score)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected)
        begin
            abort_run($sformatf("mismatch %s expected 0x%0h actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    task automatic load_patterns();
        int                      fd;
        int                      fields;
        logic [8*LINE_CHARS-1:0] line_buf;
        grid_t                   g;
        logic [7:0]              am;
        logic [7:0]              om;
        logic [11:0]             sc;
        num_vectors = 0;
        fd = $fopen("move_score_patterns.txt", "r");
        if (fd == 0)
        begin
            abort_run("cannot open the pattern file move_score_patterns.txt");
        end
        else
        begin
            while (!$feof(fd) && num_vectors < MAX_VECTORS)
            begin
                line_buf = '0;
                if ($fgets(line_buf, fd) > 0)
                begin
                    // comment and blank lines match no field
                    fields = $sscanf(line_buf, "%h %h %h %h", g, am, om, sc);
                    if (fields == 4)
                    begin
                        vec_grid[num_vectors]  = g;
                        vec_ai[num_vectors]    = move_t'(am);
                        vec_opp[num_vectors]   = move_t'(om);
                        vec_score[num_vectors] = score_t'(sc);
                        num_vectors++;
                    end
                end
            end
            $fclose(fd);
            if (num_vectors == 0)
            begin
                abort_run("the pattern file holds no vectors");
            end
        end
    endtask

    initial
    begin
        int     settle;
        score_t exp_score;
        rst_n         = 1'b0;
        grid          = '0;
        ai_move       = '0;
        opponent_move = '0;
        load_patterns();

        // score reads zero while reset is held
        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_value("score", 0, score);
        end
        rst_n = 1'b1;

        settle = 0;
        while (score === '0 && settle < SETTLE_LIMIT)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            settle++;
        end
        if (score === '0)
        begin
            abort_run("score kept its reset value long after reset was released");
        end
        else
        begin
            // empty board gives only the column 0 bonus
            check_value("score", SCORE_BASE + 1, score);
        end

        ////////////////////////////////////////
        // one vector per cycle and its score three edges later
        for (int i = 0; i < num_vectors + PIPE_LATENCY; i++)
        begin
            if (i >= PIPE_LATENCY)
            begin
                exp_score = expected_q.pop_front();
                check_value("score", exp_score, score);
            end
            if (i < num_vectors)
            begin
                grid          = vec_grid[i];
                ai_move       = vec_ai[i];
                opponent_move = vec_opp[i];
                expected_q.push_back(vec_score[i]);
            end
            else
            begin
                grid          = '0;
                ai_move       = '0;
                opponent_move = '0;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
